/* tb.f */
verilog/fiber_pkg.sv
verilog/fiber_ifs.sv
verilog/way_store.sv
verilog/replacement.sv
verilog/fiber_ctrl.sv
verilog/fiber_top.sv
tb/fiber_assertions.sv
tb/tb_fiber.sv

/* Bender.yml */
package:
  name: fiber

sources:
  - files:
      - verilog/fiber_pkg.sv
      - verilog/fiber_ifs.sv
      - verilog/way_store.sv
      - verilog/replacement.sv
      - verilog/fiber_ctrl.sv
      - verilog/fiber_top.sv
  - target: test
    files:
      - tb/fiber_assertions.sv
      - tb/tb_fiber.sv

/* tb/tb_fiber.sv */
`timescale 1ns/100ps

module tb_fiber;
    import fiber_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_TESTS = 6;
    localparam int CYCLES_PER_TEST = 200;
    // limit for any single handshake wait
    localparam int WAIT_LIMIT = 50;

    // strobe selectors
    localparam int SEL_TYPE_READY = 0;
    localparam int SEL_PE_VALID = 1;
    localparam int SEL_DRAM_RD = 2;
    localparam int SEL_DRAM_WR = 3;

    logic i_clk;
    logic i_nreset;
    req_kind_t i_req_kind;
    addr_t i_addr;
    data_t i_data;
    logic i_type_valid;
    logic o_type_ready;
    data_t o_pe_data;
    logic o_pe_data_valid;
    logic i_pe_data_ready;
    addr_t o_dram_addr;
    data_t i_dram_rd_data;
    logic i_dram_rd_valid;
    logic o_dram_rd_ready;
    data_t o_dram_wr_data;
    logic o_dram_wr_valid;
    logic i_dram_wr_ready;

    integer seed;
    int err_count;
    int check_count;
    int test_count;
    int test_err_start;
    string test_name;

    fiber_top DUT (
        .i_clk           (i_clk),
        .i_nreset        (i_nreset),
        .i_req_kind      (i_req_kind),
        .i_addr          (i_addr),
        .i_data          (i_data),
        .i_type_valid    (i_type_valid),
        .o_type_ready    (o_type_ready),
        .o_pe_data       (o_pe_data),
        .o_pe_data_valid (o_pe_data_valid),
        .i_pe_data_ready (i_pe_data_ready),
        .o_dram_addr     (o_dram_addr),
        .i_dram_rd_data  (i_dram_rd_data),
        .i_dram_rd_valid (i_dram_rd_valid),
        .o_dram_rd_ready (o_dram_rd_ready),
        .o_dram_wr_data  (o_dram_wr_data),
        .o_dram_wr_valid (o_dram_wr_valid),
        .i_dram_wr_ready (i_dram_wr_ready)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // watchdog
    initial begin
        #(CLK_PERIOD * CYCLES_PER_TEST * NUM_TESTS);
        $display("watchdog expired in test %s, run did not complete", test_name);
        $display(">>> FAIL");
        $finish;
    end

    // --------------------
    // helpers
    // --------------------
    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("error: %s %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    function automatic logic strobe_level(input int sel);
        case (sel)
            SEL_TYPE_READY: return o_type_ready;
            SEL_PE_VALID: return o_pe_data_valid;
            SEL_DRAM_RD: return o_dram_rd_ready;
            SEL_DRAM_WR: return o_dram_wr_valid;
            default: return 1'b0;
        endcase
    endfunction

    // called on a falling edge, returns on a falling edge
    task automatic wait_strobe(input int sel, input string what);
        int cycles;
        cycles = 0;
        while (!strobe_level(sel) && (cycles < WAIT_LIMIT)) begin
            @(negedge i_clk);
            cycles++;
        end
        if (!strobe_level(sel)) begin
            err_count++;
            $display("%s: %s did not rise within %0d cycles", test_name, what, WAIT_LIMIT);
        end
    endtask

    task automatic send_req(input req_kind_t kind, input addr_t addr, input data_t data);
        @(negedge i_clk);
        i_req_kind = kind;
        i_addr = addr;
        i_data = data;
        i_type_valid = 1'b1;
        wait_strobe(SEL_TYPE_READY, "o_type_ready");
        // taken on the next rising edge
        @(negedge i_clk);
        i_type_valid = 1'b0;
    endtask

    task automatic take_pe_data(input data_t expected);
        wait_strobe(SEL_PE_VALID, "o_pe_data_valid");
        check_value("pe data", expected, o_pe_data);
        i_pe_data_ready = 1'b1;
        @(negedge i_clk);
        i_pe_data_ready = 1'b0;
    endtask

    task automatic read_line(input addr_t addr, input data_t expected);
        send_req(REQ_READ, addr, '0);
        take_pe_data(expected);
        wait_strobe(SEL_TYPE_READY, "return to idle");
    endtask

    // write with no writeback expected
    task automatic write_line(input addr_t addr, input data_t data);
        send_req(REQ_WRITE, addr, data);
        wait_strobe(SEL_TYPE_READY, "return to idle");
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err_start = err_count;
    endtask

    task automatic end_test();
        test_count++;
        $display("test %s finished with %0d errors", test_name, err_count - test_err_start);
    endtask

    // --------------------
    // tests
    // --------------------
    task automatic test_reset_read();
        start_test("reset_read");
        @(negedge i_clk);
        check_value("ready after reset", 1'b1, o_type_ready);
        check_value("pe valid after reset", 1'b0, o_pe_data_valid);
        check_value("dram wr valid after reset", 1'b0, o_dram_wr_valid);
        check_value("dram rd ready after reset", 1'b0, o_dram_rd_ready);
        read_line(16'h1230, 16'h0000);
        // a second request is still taken
        read_line(16'hfe00, 16'h0000);
        end_test();
    endtask

    task automatic test_fetch_refill();
        addr_t addr;
        data_t line;
        start_test("fetch_refill");
        addr = 16'h4550;
        line = $random(seed);
        send_req(REQ_FETCH, addr, '0);
        wait_strobe(SEL_DRAM_RD, "o_dram_rd_ready");
        check_value("refill addr", addr, o_dram_addr);
        check_value("no writeback", 1'b0, o_dram_wr_valid);
        i_dram_rd_data = line;
        i_dram_rd_valid = 1'b1;
        @(negedge i_clk);
        i_dram_rd_valid = 1'b0;
        wait_strobe(SEL_TYPE_READY, "return to idle");
        read_line(addr, line);
        end_test();
    endtask

    task automatic test_write_read();
        data_t first;
        data_t second;
        start_test("write_read");
        first = $random(seed);
        second = ~first;
        write_line(16'h6670, first);
        read_line(16'h6670, first);
        // same tag again, hit
        write_line(16'h6670, second);
        read_line(16'h6670, second);
        end_test();
    endtask

    task automatic test_consume();
        data_t line;
        start_test("consume");
        line = $random(seed);
        write_line(16'h7780, line);
        send_req(REQ_CONSUME, 16'h7780, '0);
        take_pe_data(line);
        wait_strobe(SEL_TYPE_READY, "return to idle");
        // line gone after consume
        read_line(16'h7780, 16'h0000);
        end_test();
    endtask

    task automatic test_victim_writeback();
        data_t lines [5];
        start_test("victim_writeback");
        for (int i = 0; i < 5; i++) begin
            lines[i] = $random(seed);
        end
        // tags 0x10..0x40 in set 9
        for (int i = 0; i < 4; i++) begin
            write_line(addr_t'(16'h1090 + i * 16'h1000), lines[i]);
        end
        // way 0 ends with rrpv 3, lowest index at max
        send_req(REQ_WRITE, 16'h5090, lines[4]);
        wait_strobe(SEL_DRAM_WR, "o_dram_wr_valid");
        check_value("writeback addr", 16'h1090, o_dram_addr);
        check_value("writeback data", lines[0], o_dram_wr_data);
        check_value("no refill", 1'b0, o_dram_rd_ready);
        i_dram_wr_ready = 1'b1;
        @(negedge i_clk);
        i_dram_wr_ready = 1'b0;
        wait_strobe(SEL_TYPE_READY, "return to idle");
        read_line(16'h5090, lines[4]);
        read_line(16'h1090, 16'h0000);
        read_line(16'h2090, lines[1]);
        end_test();
    endtask

    task automatic test_backpressure();
        data_t line;
        start_test("backpressure");
        line = $random(seed);
        write_line(16'h8ab0, line);
        send_req(REQ_READ, 16'h8ab0, '0);
        wait_strobe(SEL_PE_VALID, "o_pe_data_valid");
        check_value("held data", line, o_pe_data);
        // hold ready low a few cycles
        repeat (5) begin
            @(negedge i_clk);
            check_value("valid under stall", 1'b1, o_pe_data_valid);
            check_value("data under stall", line, o_pe_data);
            check_value("ready under stall", 1'b0, o_type_ready);
        end
        take_pe_data(line);
        wait_strobe(SEL_TYPE_READY, "return to idle");
        check_value("valid after release", 1'b0, o_pe_data_valid);
        end_test();
    endtask

    // --------------------
    // main
    // --------------------
    initial begin
        seed = 32'hd39c304c;
        err_count = 0;
        check_count = 0;
        test_count = 0;
        test_err_start = 0;
        test_name = "reset";
        i_nreset = 1'b0;
        i_req_kind = REQ_READ;
        i_addr = '0;
        i_data = '0;
        i_type_valid = 1'b0;
        i_pe_data_ready = 1'b0;
        i_dram_rd_data = '0;
        i_dram_rd_valid = 1'b0;
        i_dram_wr_ready = 1'b0;
        repeat (8) @(posedge i_clk);
        @(negedge i_clk);
        i_nreset = 1'b1;

        test_reset_read();
        test_fetch_refill();
        test_write_read();
        test_consume();
        test_victim_writeback();
        test_backpressure();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* tb/fiber_assertions.sv */
`timescale 1ns/100ps

module fiber_assertions (
    input  logic i_clk,
    input  logic i_nreset,
    input  logic i_type_ready,
    input  logic i_pe_data_valid,
    input  logic i_pe_data_ready,
    input  fiber_pkg::data_t i_pe_data,
    input  logic i_dram_wr_valid,
    input  logic i_dram_rd_ready
);
    import fiber_pkg::*;

    // no new request while a response or DRAM transfer is open
    a_ready_idle_only: assert property (
        @(posedge i_clk) disable iff (!i_nreset)
        (i_pe_data_valid || i_dram_wr_valid || i_dram_rd_ready) |-> !i_type_ready
    ) else $error("o_type_ready high while a strobe is active");

    // writeback and refill never overlap
    a_dram_one_dir: assert property (
        @(posedge i_clk) disable iff (!i_nreset)
        !(i_dram_wr_valid && i_dram_rd_ready)
    ) else $error("o_dram_wr_valid and o_dram_rd_ready high together");

    // stalled PE response holds its line
    a_pe_data_stable: assert property (
        @(posedge i_clk) disable iff (!i_nreset)
        (i_pe_data_valid && !i_pe_data_ready) |=> $stable(i_pe_data)
    ) else $error("o_pe_data changed under back-pressure");

endmodule

bind fiber_top fiber_assertions u_assertions (
    .i_clk           (i_clk),
    .i_nreset        (i_nreset),
    .i_type_ready    (o_type_ready),
    .i_pe_data_valid (o_pe_data_valid),
    .i_pe_data_ready (i_pe_data_ready),
    .i_pe_data       (o_pe_data),
    .i_dram_wr_valid (o_dram_wr_valid),
    .i_dram_rd_ready (o_dram_rd_ready)
);

/* verilog/fiber_top.sv */
`timescale 1ns/100ps

module fiber_top (
    input  logic i_clk,
    input  logic i_nreset,

    // PE side
    input  fiber_pkg::req_kind_t i_req_kind,
    input  fiber_pkg::addr_t i_addr,
    input  fiber_pkg::data_t i_data,
    input  logic i_type_valid,
    output logic o_type_ready,
    output fiber_pkg::data_t o_pe_data,
    output logic o_pe_data_valid,
    input  logic i_pe_data_ready,

    // DRAM side
    output fiber_pkg::addr_t o_dram_addr,
    input  fiber_pkg::data_t i_dram_rd_data,
    input  logic i_dram_rd_valid,
    output logic o_dram_rd_ready,
    output fiber_pkg::data_t o_dram_wr_data,
    output logic o_dram_wr_valid,
    input  logic i_dram_wr_ready
);
    import fiber_pkg::*;

    set_read_if rd_bus ();
    set_write_if wr_bus ();

    // replacement results
    tag_t lookup_tag;
    logic hit;
    way_mask_t hit_way;
    way_mask_t victim_way;
    logic victim_dirty;
    rrpv_t new_rrpv [WAYS];

    fiber_ctrl u_ctrl (
        .i_clk           (i_clk),
        .i_nreset        (i_nreset),
        .i_req_kind      (i_req_kind),
        .i_addr          (i_addr),
        .i_data          (i_data),
        .i_type_valid    (i_type_valid),
        .o_type_ready    (o_type_ready),
        .o_pe_data       (o_pe_data),
        .o_pe_data_valid (o_pe_data_valid),
        .i_pe_data_ready (i_pe_data_ready),
        .o_dram_addr     (o_dram_addr),
        .i_dram_rd_data  (i_dram_rd_data),
        .i_dram_rd_valid (i_dram_rd_valid),
        .o_dram_rd_ready (o_dram_rd_ready),
        .o_dram_wr_data  (o_dram_wr_data),
        .o_dram_wr_valid (o_dram_wr_valid),
        .i_dram_wr_ready (i_dram_wr_ready),
        .rd              (rd_bus.ctrl),
        .wr              (wr_bus.ctrl),
        .o_lookup_tag    (lookup_tag),
        .i_hit           (hit),
        .i_hit_way       (hit_way),
        .i_victim_way    (victim_way),
        .i_victim_dirty  (victim_dirty),
        .i_new_rrpv      (new_rrpv)
    );

    way_store u_store (
        .i_clk    (i_clk),
        .i_nreset (i_nreset),
        .rd       (rd_bus.store),
        .wr       (wr_bus.store)
    );

    replacement u_repl (
        .rd             (rd_bus.user),
        .i_tag          (lookup_tag),
        .o_hit          (hit),
        .o_hit_way      (hit_way),
        .o_victim_way   (victim_way),
        .o_victim_dirty (victim_dirty),
        .o_new_rrpv     (new_rrpv)
    );

endmodule

/* verilog/fiber_ctrl.sv */
`timescale 1ns/100ps

module fiber_ctrl (
    input  logic i_clk,
    input  logic i_nreset,

    // PE side
    input  fiber_pkg::req_kind_t i_req_kind,
    input  fiber_pkg::addr_t i_addr,
    input  fiber_pkg::data_t i_data,
    input  logic i_type_valid,
    output logic o_type_ready,
    output fiber_pkg::data_t o_pe_data,
    output logic o_pe_data_valid,
    input  logic i_pe_data_ready,

    // DRAM side
    output fiber_pkg::addr_t o_dram_addr,
    input  fiber_pkg::data_t i_dram_rd_data,
    input  logic i_dram_rd_valid,
    output logic o_dram_rd_ready,
    output fiber_pkg::data_t o_dram_wr_data,
    output logic o_dram_wr_valid,
    input  logic i_dram_wr_ready,

    // way store
    set_read_if.ctrl rd,
    set_write_if.ctrl wr,

    // replacement
    output fiber_pkg::tag_t o_lookup_tag,
    input  logic i_hit,
    input  fiber_pkg::way_mask_t i_hit_way,
    input  fiber_pkg::way_mask_t i_victim_way,
    input  logic i_victim_dirty,
    input  fiber_pkg::rrpv_t i_new_rrpv [fiber_pkg::WAYS]
);
    import fiber_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_nxt;

    // captured request
    req_kind_t req_kind;
    addr_t req_addr;
    data_t req_data;
    set_idx_t req_set;
    tag_t req_tag;

    // way picked for refill, kept across writeback
    way_mask_t fill_way;
    addr_t wb_addr;

    logic accept;
    logic lookup;
    logic wb_needed;
    data_t hit_line;
    data_t victim_line;
    tag_t victim_tag;

    assign o_type_ready = (state == ST_IDLE);
    assign accept = i_type_valid && o_type_ready;
    assign lookup = (state == ST_LOOKUP);

    assign req_set = req_addr[OFFSET_W +: SET_W];
    assign req_tag = req_addr[ADDR_W-1 -: TAG_W];
    assign o_lookup_tag = req_tag;

    // set read in the accept cycle
    assign rd.rd_en = accept;
    assign rd.rd_set = i_addr[OFFSET_W +: SET_W];

    // writeback on fetch or write miss with a dirty victim
    assign wb_needed = lookup && !i_hit && i_victim_dirty
        && ((req_kind == REQ_FETCH) || (req_kind == REQ_WRITE));

    // pick hit and victim lines out of the set
    always_comb begin
        hit_line = '0;
        victim_line = '0;
        victim_tag = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (i_hit_way[w]) begin
                hit_line = hit_line | rd.rd_data[w];
            end
            if (i_victim_way[w]) begin
                victim_line = victim_line | rd.rd_data[w];
                victim_tag = victim_tag | rd.rd_tag[w];
            end
        end
    end

    // --------------------
    // FSM
    // --------------------
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    state_nxt = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if ((req_kind == REQ_READ) || (req_kind == REQ_CONSUME)) begin
                    state_nxt = ST_SEND_PE;
                end else if ((req_kind == REQ_FETCH) && !i_hit) begin
                    state_nxt = i_victim_dirty ? ST_WB_THEN_FILL : ST_FILL;
                end else if ((req_kind == REQ_WRITE) && !i_hit && i_victim_dirty) begin
                    state_nxt = ST_WB_ONLY;
                end else begin
                    state_nxt = ST_IDLE;
                end
            end
            ST_SEND_PE: begin
                if (i_pe_data_ready) begin
                    state_nxt = ST_IDLE;
                end
            end
            ST_WB_THEN_FILL: begin
                if (i_dram_wr_ready) begin
                    state_nxt = ST_FILL;
                end
            end
            ST_WB_ONLY: begin
                if (i_dram_wr_ready) begin
                    state_nxt = ST_IDLE;
                end
            end
            ST_FILL: begin
                if (i_dram_rd_valid) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_nreset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // request and response registers
    always_ff @(posedge i_clk) begin
        if (accept) begin
            req_kind <= i_req_kind;
            req_addr <= i_addr;
            req_data <= i_data;
        end
        // miss on read or consume gives zero
        if (lookup && ((req_kind == REQ_READ) || (req_kind == REQ_CONSUME))) begin
            o_pe_data <= hit_line;
        end
        if (lookup && (req_kind == REQ_FETCH)) begin
            fill_way <= i_victim_way;
        end
        if (wb_needed) begin
            o_dram_wr_data <= victim_line;
            wb_addr <= {victim_tag, req_set, {OFFSET_W{1'b0}}};
        end
    end

    // --------------------
    // array writes
    // --------------------
    always_comb begin
        wr.wr_set = req_set;
        wr.wr_way = '0;
        wr.tag_we = 1'b0;
        wr.data_we = 1'b0;
        wr.dirty_we = 1'b0;
        wr.valid_we = 1'b0;
        wr.rrpv_we = 1'b0;
        wr.wr_tag = req_tag;
        wr.wr_data = req_data;
        wr.wr_dirty = 1'b0;
        wr.wr_valid = 1'b1;
        wr.wr_rrpv = i_new_rrpv;
        if (lookup) begin
            case (req_kind)
                REQ_FETCH: begin
                    // line itself arrives later in ST_FILL
                    wr.rrpv_we = 1'b1;
                end
                REQ_READ: begin
                    wr.rrpv_we = i_hit;
                end
                REQ_WRITE: begin
                    wr.wr_way = i_hit ? i_hit_way : i_victim_way;
                    wr.tag_we = 1'b1;
                    wr.data_we = 1'b1;
                    wr.dirty_we = 1'b1;
                    wr.valid_we = 1'b1;
                    wr.wr_dirty = 1'b1;
                    wr.rrpv_we = 1'b1;
                end
                REQ_CONSUME: begin
                    // invalidate, rrpv left alone
                    wr.wr_way = i_hit_way;
                    wr.valid_we = i_hit;
                    wr.wr_valid = 1'b0;
                end
                default: begin
                    wr.wr_way = '0;
                end
            endcase
        end else if ((state == ST_FILL) && i_dram_rd_valid) begin
            // refill, clean and valid
            wr.wr_way = fill_way;
            wr.tag_we = 1'b1;
            wr.data_we = 1'b1;
            wr.dirty_we = 1'b1;
            wr.valid_we = 1'b1;
            wr.wr_data = i_dram_rd_data;
        end
    end

    // --------------------
    // strobes
    // --------------------
    assign o_pe_data_valid = (state == ST_SEND_PE);
    assign o_dram_wr_valid = (state == ST_WB_THEN_FILL) || (state == ST_WB_ONLY);
    assign o_dram_rd_ready = (state == ST_FILL);
    // refill uses the request address, writeback the victim's
    assign o_dram_addr = (state == ST_FILL) ? req_addr : wb_addr;

endmodule

/* verilog/replacement.sv */
`timescale 1ns/100ps

module replacement (
    set_read_if.user rd,
    input  fiber_pkg::tag_t i_tag,
    output logic o_hit,
    output fiber_pkg::way_mask_t o_hit_way,
    output fiber_pkg::way_mask_t o_victim_way,
    output logic o_victim_dirty,
    output fiber_pkg::rrpv_t o_new_rrpv [fiber_pkg::WAYS]
);
    import fiber_pkg::*;

    way_mask_t hit_vec;
    way_mask_t victim_vec;
    logic victim_found;
    rrpv_t max_rrpv;
    rrpv_t rrpv_inc [WAYS];

    // --------------------
    // tag compare
    // --------------------
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w] = rd.rd_valid[w] && (rd.rd_tag[w] == i_tag);
        end
    end

    assign o_hit = |hit_vec;
    assign o_hit_way = hit_vec;

    // --------------------
    // victim choice
    // --------------------
    // highest rrpv in the set
    always_comb begin
        max_rrpv = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (rd.rd_rrpv[w] > max_rrpv) begin
                max_rrpv = rd.rd_rrpv[w];
            end
        end
    end

    // first invalid way wins, else lowest index holding max rrpv
    always_comb begin
        victim_vec = '0;
        victim_found = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            if (!victim_found && !rd.rd_valid[w]) begin
                victim_vec[w] = 1'b1;
                victim_found = 1'b1;
            end
        end
        for (int w = 0; w < WAYS; w++) begin
            if (!victim_found && (rd.rd_rrpv[w] == max_rrpv)) begin
                victim_vec[w] = 1'b1;
                victim_found = 1'b1;
            end
        end
    end

    assign o_victim_way = victim_vec;
    // an invalid victim never needs a writeback
    assign o_victim_dirty = |(victim_vec & rd.rd_valid & rd.rd_dirty);

    // --------------------
    // rrpv update
    // --------------------
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            // saturating age step
            if (rd.rd_rrpv[w] == {RRPV_W{1'b1}}) begin
                rrpv_inc[w] = rd.rd_rrpv[w];
            end else begin
                rrpv_inc[w] = rd.rd_rrpv[w] + rrpv_t'(1);
            end
        end
    end

    // hit promotes the hit way, miss inserts the victim
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            if (o_hit) begin
                o_new_rrpv[w] = hit_vec[w] ? rrpv_t'(0) : rrpv_inc[w];
            end else begin
                o_new_rrpv[w] = victim_vec[w] ? rrpv_t'(RRPV_INSERT) : rrpv_inc[w];
            end
        end
    end

endmodule

/* verilog/way_store.sv */
`timescale 1ns/100ps

module way_store (
    input  logic i_clk,
    input  logic i_nreset,
    set_read_if.store rd,
    set_write_if.store wr
);
    import fiber_pkg::*;

    // --------------------
    // arrays
    // --------------------
    tag_t tag_mem [SETS][WAYS];
    data_t data_mem [SETS][WAYS];
    way_mask_t dirty_mem [SETS];
    // replacement state
    way_mask_t valid_mem [SETS];
    rrpv_t rrpv_mem [SETS][WAYS];

    // valid and rrpv, cleared on reset
    always_ff @(posedge i_clk) begin
        if (!i_nreset) begin
            for (int s = 0; s < SETS; s++) begin
                valid_mem[s] <= '0;
                for (int w = 0; w < WAYS; w++) begin
                    rrpv_mem[s][w] <= '0;
                end
            end
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                // valid follows the way mask
                if (wr.valid_we && wr.wr_way[w]) begin
                    valid_mem[wr.wr_set][w] <= wr.wr_valid;
                end
                // rrpv ignores the mask, all ways at once
                if (wr.rrpv_we) begin
                    rrpv_mem[wr.wr_set][w] <= wr.wr_rrpv[w];
                end
            end
        end
    end

    // tag, data and dirty, masked per way
    always_ff @(posedge i_clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (wr.wr_way[w]) begin
                if (wr.tag_we) begin
                    tag_mem[wr.wr_set][w] <= wr.wr_tag;
                end
                if (wr.data_we) begin
                    data_mem[wr.wr_set][w] <= wr.wr_data;
                end
                if (wr.dirty_we) begin
                    dirty_mem[wr.wr_set][w] <= wr.wr_dirty;
                end
            end
        end
    end

    // --------------------
    // set read
    // --------------------
    // whole set lands in the output regs one cycle after rd_en
    always_ff @(posedge i_clk) begin
        if (rd.rd_en) begin
            rd.rd_valid <= valid_mem[rd.rd_set];
            rd.rd_dirty <= dirty_mem[rd.rd_set];
            for (int w = 0; w < WAYS; w++) begin
                rd.rd_tag[w] <= tag_mem[rd.rd_set][w];
                rd.rd_data[w] <= data_mem[rd.rd_set][w];
                rd.rd_rrpv[w] <= rrpv_mem[rd.rd_set][w];
            end
        end
    end

endmodule

/* verilog/fiber_ifs.sv */
`timescale 1ns/100ps

// set read port of the way store
interface set_read_if;
    import fiber_pkg::*;

    // request side
    logic rd_en;
    set_idx_t rd_set;

    // whole set, registered, valid the cycle after rd_en
    tag_t rd_tag [WAYS];
    way_mask_t rd_valid;
    way_mask_t rd_dirty;
    rrpv_t rd_rrpv [WAYS];
    data_t rd_data [WAYS];

    modport store (
        input  rd_en, rd_set,
        output rd_tag, rd_valid, rd_dirty, rd_rrpv, rd_data
    );

    // replacement logic only looks at the set contents
    modport user (
        input  rd_tag, rd_valid, rd_dirty, rd_rrpv
    );

    // controller issues the read and picks lines out of the set
    modport ctrl (
        output rd_en, rd_set,
        input  rd_tag, rd_data
    );
endinterface

// masked way write port of the way store
interface set_write_if;
    import fiber_pkg::*;

    set_idx_t wr_set;
    way_mask_t wr_way;

    // per-field enables
    logic tag_we;
    logic data_we;
    logic dirty_we;
    logic valid_we;
    // rrpv write covers every way of the set
    logic rrpv_we;

    tag_t wr_tag;
    data_t wr_data;
    logic wr_dirty;
    logic wr_valid;
    rrpv_t wr_rrpv [WAYS];

    modport ctrl (
        output wr_set, wr_way, tag_we, data_we, dirty_we, valid_we, rrpv_we,
        output wr_tag, wr_data, wr_dirty, wr_valid, wr_rrpv
    );

    modport store (
        input  wr_set, wr_way, tag_we, data_we, dirty_we, valid_we, rrpv_we,
        input  wr_tag, wr_data, wr_dirty, wr_valid, wr_rrpv
    );
endinterface

/* verilog/fiber_pkg.sv */
package fiber_pkg;

    // --------------------
    // geometry
    // --------------------
    localparam int SETS = 16;
    localparam int WAYS = 4;

    localparam int ADDR_W = 16;
    localparam int DATA_W = 16;

    // address split, tag | set | offset
    localparam int OFFSET_W = 4;
    localparam int SET_W = 4;
    localparam int TAG_W = 8;

    // re-reference prediction
    localparam int RRPV_W = 2;
    // new lines go in one step short of distant
    localparam int RRPV_INSERT = 2;

    // --------------------
    // types
    // --------------------
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [SET_W-1:0] set_idx_t;
    typedef logic [TAG_W-1:0] tag_t;
    // one bit per way, one-hot or empty
    typedef logic [WAYS-1:0] way_mask_t;
    typedef logic [RRPV_W-1:0] rrpv_t;

    // one-hot request code from the PE
    typedef logic [3:0] req_kind_t;
    localparam req_kind_t REQ_FETCH = 4'b0001;
    localparam req_kind_t REQ_READ = 4'b0010;
    localparam req_kind_t REQ_WRITE = 4'b0100;
    localparam req_kind_t REQ_CONSUME = 4'b1000;

    // controller FSM
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_SEND_PE,
        ST_WB_THEN_FILL,
        ST_WB_ONLY,
        ST_FILL
    } ctrl_state_e;

endpackage
